// File: src/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Word width for addresses and instructions
`define FETCH_XLEN 32

// Direct-mapped BTB rows, indexed by PC bits above bit 1
`define FETCH_BTB_ENTRIES 32

// Return address stack entries
`define FETCH_RAS_DEPTH 8

// First fetch address after reset
`define FETCH_RESET_PC 32'haaaaa000

`endif

// File: src/fetch_pkg.sv
`include "fetch_settings.svh"

package fetch_pkg;

    // One word of address or instruction
    typedef logic [`FETCH_XLEN-1:0] addr_t;

    // Fetch sequencer states
    typedef enum logic {
        FETCH_IDLE,
        FETCH_WAIT
    } fetch_state_t;

    // Control-flow major opcodes seen by the predecoder
    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_t;

    // Tag is the full PC of the branch
    typedef struct packed {
        logic  valid;
        addr_t tag;
        addr_t target;
    } btb_entry_t;

endpackage

// File: src/ras_if.sv
interface ras_if;

    logic             push;
    fetch_pkg::addr_t push_addr;
    logic             pop;
    fetch_pkg::addr_t top_addr;
    logic             empty;

    // Predecoder side
    modport client (output push, push_addr, pop, input top_addr, empty);

    // Stack side
    modport stack (input push, push_addr, pop, output top_addr, empty);

endinterface

// File: src/fetch_fsm.sv
`include "fetch_settings.svh"

module fetch_fsm (
    input  logic             clk,
    input  logic             rst,
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             icache_req_ready,
    input  logic             icache_resp_valid,
    input  fetch_pkg::addr_t icache_resp_data,
    input  logic             inst_ready,
    input  logic             pred_taken,
    input  fetch_pkg::addr_t pred_target,
    output logic             icache_req_valid,
    output fetch_pkg::addr_t icache_req_addr,
    output fetch_pkg::addr_t pc,
    output logic             issue,
    output fetch_pkg::addr_t issue_word,
    output logic             inst_valid,
    output fetch_pkg::addr_t inst,
    output fetch_pkg::addr_t inst_pc,
    output logic             inst_pred_taken,
    output fetch_pkg::addr_t inst_pred_target
);

    fetch_pkg::fetch_state_t state;
    logic                    waiting;
    logic                    slot_free;
    logic                    hold_load;
    logic                    hold_valid;
    fetch_pkg::addr_t        hold_data;

    // Output slot can take a new item this cycle
    assign slot_free = !inst_valid || inst_ready;
    assign waiting   = (state == fetch_pkg::FETCH_WAIT);

    assign icache_req_valid = !rst && !redirect_valid
                              && (state == fetch_pkg::FETCH_IDLE) && slot_free;
    assign icache_req_addr  = {pc[`FETCH_XLEN-1:2], 2'b00};

    // Buffer the response while the queue stalls
    assign hold_load  = waiting && icache_resp_valid && !slot_free;

    // Hold buffer first; it only fills when no response can follow
    assign issue      = !redirect_valid && waiting && slot_free
                        && (hold_valid || icache_resp_valid);
    assign issue_word = hold_valid ? hold_data : icache_resp_data;

    // ----------------------------------------
    // Control state
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= fetch_pkg::FETCH_IDLE;
            pc         <= `FETCH_RESET_PC;
            hold_valid <= 1'b0;
            inst_valid <= 1'b0;
        end else if (redirect_valid) begin
            state      <= fetch_pkg::FETCH_IDLE;
            pc         <= redirect_pc;
            hold_valid <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            if (icache_req_valid && icache_req_ready) begin
                state <= fetch_pkg::FETCH_WAIT;
            end
            if (hold_load) begin
                hold_valid <= 1'b1;
            end
            if (issue) begin
                // Follow the prediction for the next request
                state      <= fetch_pkg::FETCH_IDLE;
                pc         <= pred_target;
                hold_valid <= 1'b0;
                inst_valid <= 1'b1;
            end else if (inst_ready) begin
                inst_valid <= 1'b0;
            end
        end
    end

    // Payload toward the queue and the hold word
    always_ff @(posedge clk) begin
        if (issue) begin
            inst             <= issue_word;
            inst_pc          <= pc;
            inst_pred_taken  <= pred_taken;
            inst_pred_target <= pred_target;
        end
        if (hold_load) begin
            hold_data <= icache_resp_data;
        end
    end

endmodule

// File: src/branch_target_buffer.sv
`include "fetch_settings.svh"

module branch_target_buffer (
    input  logic             clk,
    input  logic             rst,
    input  fetch_pkg::addr_t lookup_pc,
    input  logic             update_valid,
    input  fetch_pkg::addr_t update_pc,
    input  fetch_pkg::addr_t update_target,
    output logic             hit,
    output fetch_pkg::addr_t target
);

    localparam int IDX_W = $clog2(`FETCH_BTB_ENTRIES);

    fetch_pkg::btb_entry_t entries [`FETCH_BTB_ENTRIES];
    fetch_pkg::btb_entry_t lookup_entry;
    logic [IDX_W-1:0]      lookup_idx;
    logic [IDX_W-1:0]      update_idx;

    // Word-aligned index, low two bits skipped
    assign lookup_idx = lookup_pc[IDX_W+1:2];
    assign update_idx = update_pc[IDX_W+1:2];

    assign lookup_entry = entries[lookup_idx];

    // Full PC tag, so aliasing rows never hit
    assign hit    = lookup_entry.valid && (lookup_entry.tag == lookup_pc);
    assign target = lookup_entry.target;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `FETCH_BTB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (update_valid) begin
            // Last writer owns the row
            entries[update_idx] <= '{valid: 1'b1, tag: update_pc, target: update_target};
        end
    end

endmodule

// File: src/return_stack.sv
`include "fetch_settings.svh"

module return_stack (
    input logic  clk,
    input logic  rst,
    input logic  flush,
    ras_if.stack ras
);

    localparam int PTR_W = $clog2(`FETCH_RAS_DEPTH);
    localparam int CNT_W = $clog2(`FETCH_RAS_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(`FETCH_RAS_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(`FETCH_RAS_DEPTH);

    fetch_pkg::addr_t stack_mem [`FETCH_RAS_DEPTH];
    logic [PTR_W-1:0] top_ptr;
    logic [PTR_W-1:0] next_ptr;
    logic [PTR_W-1:0] prev_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;
    logic             do_replace;

    assign next_ptr = (top_ptr == LAST) ? '0 : top_ptr + 1'b1;
    assign prev_ptr = (top_ptr == '0) ? LAST : top_ptr - 1'b1;

    assign ras.top_addr = stack_mem[top_ptr];
    assign ras.empty    = (count == '0);

    // Pop and push together replace the top; on an empty stack it is a plain push
    assign do_replace = ras.push && ras.pop && !ras.empty;
    assign do_push    = ras.push && !do_replace;
    assign do_pop     = ras.pop && !ras.push && !ras.empty;

    // Pointer and occupancy, saturating at depth so the oldest entry is lost
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            top_ptr <= '0;
            count   <= '0;
        end else if (do_push) begin
            top_ptr <= next_ptr;
            if (count != FULL) begin
                count <= count + 1'b1;
            end
        end else if (do_pop) begin
            top_ptr <= prev_ptr;
            count   <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_mem[next_ptr] <= ras.push_addr;
        end else if (do_replace) begin
            stack_mem[top_ptr] <= ras.push_addr;
        end
    end

endmodule

// File: src/branch_predecode.sv
module branch_predecode (
    input  logic             issue,
    input  fetch_pkg::addr_t issue_word,
    input  fetch_pkg::addr_t pc,
    input  logic             btb_hit,
    input  fetch_pkg::addr_t btb_target,
    ras_if.client            ras,
    output logic             pred_taken,
    output fetch_pkg::addr_t pred_target
);

    fetch_pkg::opcode_t opcode;
    logic               is_branch;
    logic               is_jal;
    logic               is_jalr;
    logic               is_jump;
    logic [4:0]         rd;
    logic [4:0]         rs1;
    logic               rd_link;
    logic               rs1_link;
    fetch_pkg::addr_t   b_imm;
    fetch_pkg::addr_t   j_imm;
    fetch_pkg::addr_t   pc_plus4;

    // ----------------------------------------
    // Field decode
    // ----------------------------------------
    assign opcode    = fetch_pkg::opcode_t'(issue_word[6:0]);
    assign is_branch = (opcode == fetch_pkg::OP_BRANCH);
    assign is_jal    = (opcode == fetch_pkg::OP_JAL);
    assign is_jalr   = (opcode == fetch_pkg::OP_JALR);
    assign is_jump   = is_jal || is_jalr;

    assign rd  = issue_word[11:7];
    assign rs1 = issue_word[19:15];

    // x1 and x5 are the link registers
    assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
    assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

    assign b_imm = {{20{issue_word[31]}}, issue_word[7], issue_word[30:25],
                    issue_word[11:8], 1'b0};
    assign j_imm = {{12{issue_word[31]}}, issue_word[19:12], issue_word[20],
                    issue_word[30:21], 1'b0};

    assign pc_plus4 = pc + 32'd4;

    // Stack action per link table, jumps only
    assign ras.push_addr = pc_plus4;

    always_comb begin
        ras.push = 1'b0;
        ras.pop  = 1'b0;
        if (issue && is_jump) begin
            case ({rd_link, rs1_link})
                2'b01: ras.pop = 1'b1;
                2'b10: ras.push = 1'b1;
                2'b11: begin
                    ras.push = 1'b1;
                    ras.pop  = (rd != rs1);
                end
                default: ;
            endcase
        end
    end

    // ----------------------------------------
    // Next-PC choice
    // ----------------------------------------
    always_comb begin
        pred_taken  = is_jump || (is_branch && btb_hit);
        pred_target = pc_plus4;
        if (pred_taken) begin
            if (is_jalr && rs1_link && !ras.empty) begin
                pred_target = ras.top_addr;
            end else if (btb_hit) begin
                pred_target = btb_target;
            end else if (is_jal) begin
                pred_target = pc + j_imm;
            end else if (is_branch) begin
                pred_target = pc + b_imm;
            end
        end
    end

endmodule

// File: src/fetch_stage.sv
module fetch_stage (
    input  logic             clk,
    input  logic             rst,

    // Redirect from the back end
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,

    // Instruction cache
    output logic             icache_req_valid,
    output fetch_pkg::addr_t icache_req_addr,
    input  logic             icache_req_ready,
    input  logic             icache_resp_valid,
    input  fetch_pkg::addr_t icache_resp_data,

    // Instruction queue
    output logic             inst_valid,
    output fetch_pkg::addr_t inst,
    output fetch_pkg::addr_t inst_pc,
    output logic             inst_pred_taken,
    output fetch_pkg::addr_t inst_pred_target,
    input  logic             inst_ready,

    // BTB writes from the back end
    input  logic             btb_update_valid,
    input  fetch_pkg::addr_t btb_update_pc,
    input  fetch_pkg::addr_t btb_update_target
);

    fetch_pkg::addr_t pc;
    logic             issue;
    fetch_pkg::addr_t issue_word;
    logic             pred_taken;
    fetch_pkg::addr_t pred_target;
    logic             btb_hit;
    fetch_pkg::addr_t btb_target;

    ras_if ras_bus ();

    fetch_fsm fetch_fsm_inst (
        .clk              (clk),
        .rst              (rst),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc),
        .icache_req_ready (icache_req_ready),
        .icache_resp_valid(icache_resp_valid),
        .icache_resp_data (icache_resp_data),
        .inst_ready       (inst_ready),
        .pred_taken       (pred_taken),
        .pred_target      (pred_target),
        .icache_req_valid (icache_req_valid),
        .icache_req_addr  (icache_req_addr),
        .pc               (pc),
        .issue            (issue),
        .issue_word       (issue_word),
        .inst_valid       (inst_valid),
        .inst             (inst),
        .inst_pc          (inst_pc),
        .inst_pred_taken  (inst_pred_taken),
        .inst_pred_target (inst_pred_target)
    );

    branch_target_buffer branch_target_buffer_inst (
        .clk          (clk),
        .rst          (rst),
        .lookup_pc    (pc),
        .update_valid (btb_update_valid),
        .update_pc    (btb_update_pc),
        .update_target(btb_update_target),
        .hit          (btb_hit),
        .target       (btb_target)
    );

    // Redirect empties the stack
    return_stack return_stack_inst (
        .clk  (clk),
        .rst  (rst),
        .flush(redirect_valid),
        .ras  (ras_bus.stack)
    );

    branch_predecode branch_predecode_inst (
        .issue      (issue),
        .issue_word (issue_word),
        .pc         (pc),
        .btb_hit    (btb_hit),
        .btb_target (btb_target),
        .ras        (ras_bus.client),
        .pred_taken (pred_taken),
        .pred_target(pred_target)
    );

endmodule

// File: bench/fetch_stage_sva.sv
module fetch_stage_sva (
    input logic clk,
    input logic rst,
    input logic redirect_valid,
    input logic icache_req_valid,
    input logic icache_req_ready,
    input logic issue,
    input logic inst_valid,
    input logic inst_ready,
    input logic [31:0] inst,
    input logic [31:0] inst_pc
);

    timeunit 1ns;
    timeprecision 1ps;

    logic outstanding;

    // A fetch is outstanding from acceptance until it issues or is flushed
    always_ff @(posedge clk) begin
        if (rst || redirect_valid || issue) begin
            outstanding <= 1'b0;
        end else if (icache_req_valid && icache_req_ready) begin
            outstanding <= 1'b1;
        end
    end

    // Request stays up until the cache takes it
    assert property (@(posedge clk) disable iff (rst)
        icache_req_valid && !icache_req_ready |=> icache_req_valid || redirect_valid)
        else $error("icache request dropped before acceptance");

    // Stalled item keeps its valid and payload
    assert property (@(posedge clk) disable iff (rst)
        inst_valid && !inst_ready && !redirect_valid |=> inst_valid && $stable(inst)
        && $stable(inst_pc))
        else $error("queue output changed during stall");

    // No new request for the whole time a fetch is outstanding
    assert property (@(posedge clk) disable iff (rst)
        outstanding |-> !icache_req_valid)
        else $error("request raised while a fetch is outstanding");

endmodule

// File: bench/fetch_checker.sv
`include "fetch_settings.svh"

module fetch_checker (
    input  logic             clk,
    input  logic             rst,
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_pc,
    input  logic             icache_req_valid,
    input  fetch_pkg::addr_t icache_req_addr,
    input  logic             icache_req_ready,
    input  logic             icache_resp_valid,
    input  fetch_pkg::addr_t icache_resp_data,
    input  logic             inst_valid,
    input  fetch_pkg::addr_t inst,
    input  fetch_pkg::addr_t inst_pc,
    input  logic             inst_pred_taken,
    input  fetch_pkg::addr_t inst_pred_target,
    input  logic             inst_ready,
    input  logic             btb_update_valid,
    input  fetch_pkg::addr_t btb_update_pc,
    input  fetch_pkg::addr_t btb_update_target,
    input  logic             done,
    output int               error_count,
    output int               item_count
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int IDX_W = $clog2(`FETCH_BTB_ENTRIES);

    // Model BTB, model stack and the words the cache returned
    logic             btb_vld [`FETCH_BTB_ENTRIES];
    fetch_pkg::addr_t btb_tag [`FETCH_BTB_ENTRIES];
    fetch_pkg::addr_t btb_tgt [`FETCH_BTB_ENTRIES];
    fetch_pkg::addr_t ras_q [$];
    fetch_pkg::addr_t words [fetch_pkg::addr_t];

    logic             pend_upd;
    fetch_pkg::addr_t pend_pc;
    fetch_pkg::addr_t pend_tgt;
    fetch_pkg::addr_t expect_pc;
    fetch_pkg::addr_t expect_req;
    fetch_pkg::addr_t req_addr;
    logic             checked;
    logic             stalled;
    logic             rst_seen;
    logic             first_req;
    logic             after_redirect;
    fetch_pkg::addr_t s_inst;
    fetch_pkg::addr_t s_pc;
    fetch_pkg::addr_t s_target;
    logic             s_taken;
    int               errs [5];
    string            test_name [5] = '{"reset", "order", "prediction", "backpressure",
                                        "redirect"};

    initial begin
        error_count = 0;
        item_count  = 0;
        rst_seen    = 1'b0;
        for (int i = 0; i < 5; i++) begin
            errs[i] = 0;
        end
    end

    task automatic compare_value(input int t, input fetch_pkg::addr_t exp,
                                 input fetch_pkg::addr_t act);
        if (exp !== act) begin
            errs[t]++;
            error_count++;
            $display("[ERROR] %s expected %h actual %h at %0t", test_name[t], exp, act,
                     $time);
        end
    endtask

    task automatic report_problem(input int t, input string what);
        errs[t]++;
        error_count++;
        $display("%s check failed at %0t: %s", test_name[t], $time, what);
    endtask

    task automatic push_return(input fetch_pkg::addr_t addr);
        ras_q.push_back(addr);
        // Overflow loses the oldest return address
        if (ras_q.size() > `FETCH_RAS_DEPTH) begin
            void'(ras_q.pop_front());
        end
    endtask

    // ----------------------------------------
    // Reference prediction for one new item
    // ----------------------------------------
    task automatic process_item();
        fetch_pkg::addr_t   key;
        fetch_pkg::addr_t   tgt;
        fetch_pkg::addr_t   pc4;
        fetch_pkg::addr_t   b_imm;
        fetch_pkg::addr_t   j_imm;
        fetch_pkg::opcode_t op;
        logic [IDX_W-1:0]   idx;
        logic [4:0]         rd;
        logic [4:0]         rs1;
        logic               rdl;
        logic               rs1l;
        logic               hit;
        logic               jump;
        logic               taken;

        key = {inst_pc[31:2], 2'b00};
        compare_value(1, expect_pc, inst_pc);
        if (words.exists(key)) begin
            compare_value(1, words[key], inst);
        end else begin
            report_problem(1, "instruction issued for an address the cache never returned");
        end

        op    = fetch_pkg::opcode_t'(inst[6:0]);
        rd    = inst[11:7];
        rs1   = inst[19:15];
        rdl   = (rd == 5'd1) || (rd == 5'd5);
        rs1l  = (rs1 == 5'd1) || (rs1 == 5'd5);
        b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        pc4   = inst_pc + 32'd4;
        idx   = inst_pc[IDX_W+1:2];
        hit   = btb_vld[idx] && (btb_tag[idx] == inst_pc);
        jump  = (op == fetch_pkg::OP_JAL) || (op == fetch_pkg::OP_JALR);
        taken = jump || ((op == fetch_pkg::OP_BRANCH) && hit);

        tgt = pc4;
        if (taken) begin
            if (op == fetch_pkg::OP_JALR && rs1l && ras_q.size() > 0) begin
                tgt = ras_q[ras_q.size() - 1];
            end else if (hit) begin
                tgt = btb_tgt[idx];
            end else if (op == fetch_pkg::OP_JAL) begin
                tgt = inst_pc + j_imm;
            end else if (op == fetch_pkg::OP_BRANCH) begin
                tgt = inst_pc + b_imm;
            end
        end
        compare_value(2, {31'd0, taken}, {31'd0, inst_pred_taken});
        compare_value(2, tgt, inst_pred_target);

        // Link register push/pop table
        if (jump) begin
            case ({rdl, rs1l})
                2'b01: begin
                    if (ras_q.size() > 0) begin
                        void'(ras_q.pop_back());
                    end
                end
                2'b10: push_return(pc4);
                2'b11: begin
                    if (rd != rs1 && ras_q.size() > 0) begin
                        ras_q[ras_q.size() - 1] = pc4;
                    end else begin
                        push_return(pc4);
                    end
                end
                default: ;
            endcase
        end

        expect_pc      = tgt;
        expect_req     = {tgt[31:2], 2'b00};
        after_redirect = 1'b0;
        item_count++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            if (rst_seen && (inst_valid !== 1'b0 || icache_req_valid !== 1'b0)) begin
                report_problem(0, "inst_valid or icache_req_valid is high during reset");
            end
            rst_seen       = 1'b1;
            ras_q.delete();
            for (int i = 0; i < `FETCH_BTB_ENTRIES; i++) begin
                btb_vld[i] = 1'b0;
            end
            expect_pc      = `FETCH_RESET_PC;
            expect_req     = `FETCH_RESET_PC;
            checked        = 1'b0;
            stalled        = 1'b0;
            pend_upd       = 1'b0;
            first_req      = 1'b1;
            after_redirect = 1'b0;
        end else begin
            if (first_req && inst_valid !== 1'b0) begin
                report_problem(0, "inst_valid rose before the first request");
            end
            if (stalled) begin
                if (!inst_valid || inst !== s_inst || inst_pc !== s_pc
                    || inst_pred_taken !== s_taken || inst_pred_target !== s_target) begin
                    report_problem(3, "queue output changed while inst_ready was low");
                end
            end
            if (inst_valid && !checked) begin
                process_item();
                checked = 1'b1;
            end
            if (!inst_valid || inst_ready || redirect_valid) begin
                checked = 1'b0;
            end
            stalled  = inst_valid && !inst_ready && !redirect_valid;
            s_inst   = inst;
            s_pc     = inst_pc;
            s_taken  = inst_pred_taken;
            s_target = inst_pred_target;

            // BTB writes become visible one cycle after the edge that takes them
            if (pend_upd) begin
                btb_vld[pend_pc[IDX_W+1:2]] = 1'b1;
                btb_tag[pend_pc[IDX_W+1:2]] = pend_pc;
                btb_tgt[pend_pc[IDX_W+1:2]] = pend_tgt;
            end
            pend_upd = btb_update_valid;
            pend_pc  = btb_update_pc;
            pend_tgt = btb_update_target;

            if (icache_req_valid && icache_req_ready) begin
                if (first_req) begin
                    compare_value(0, `FETCH_RESET_PC, icache_req_addr);
                end else if (after_redirect) begin
                    compare_value(4, expect_req, icache_req_addr);
                end else begin
                    compare_value(1, expect_req, icache_req_addr);
                end
                first_req      = 1'b0;
                after_redirect = 1'b0;
                req_addr       = icache_req_addr;
            end
            if (icache_resp_valid) begin
                words[req_addr] = icache_resp_data;
            end
            if (redirect_valid) begin
                ras_q.delete();
                expect_pc      = redirect_pc;
                expect_req     = {redirect_pc[31:2], 2'b00};
                after_redirect = 1'b1;
                first_req      = 1'b0;
            end
        end
    end

    always @(posedge done) begin
        for (int i = 0; i < 5; i++) begin
            $display("test %s: %0d errors", test_name[i], errs[i]);
        end
        $display("summary: %0d items checked, %0d errors", item_count, error_count);
    end

endmodule

// File: bench/tb_fetch_stage.sv
`include "fetch_settings.svh"

module tb_fetch_stage;

    timeunit 1ns;
    timeprecision 1ps;

    logic             clk;
    logic             rst;
    logic             redirect_valid;
    fetch_pkg::addr_t redirect_pc;
    logic             icache_req_valid;
    fetch_pkg::addr_t icache_req_addr;
    logic             icache_req_ready;
    logic             icache_resp_valid;
    fetch_pkg::addr_t icache_resp_data;
    logic             inst_valid;
    fetch_pkg::addr_t inst;
    fetch_pkg::addr_t inst_pc;
    logic             inst_pred_taken;
    fetch_pkg::addr_t inst_pred_target;
    logic             inst_ready;
    logic             btb_update_valid;
    fetch_pkg::addr_t btb_update_pc;
    fetch_pkg::addr_t btb_update_target;
    logic             done;
    int               error_count;
    int               item_count;

    logic [31:0]      rng;
    logic             accept;
    logic             active;
    fetch_pkg::addr_t req_addr_q;
    logic             pending;
    fetch_pkg::addr_t pend_addr;
    int               pend_cnt;
    int               stall_cnt;
    logic             ok;

    always #20 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [4:0] pick_reg(input logic [1:0] sel);
        case (sel)
            2'd0: return 5'd0;
            2'd1: return 5'd1;
            2'd2: return 5'd5;
            default: return 5'd7;
        endcase
    endfunction

    // Cache content, a hash of the word address
    function automatic fetch_pkg::addr_t mem_word(input fetch_pkg::addr_t addr);
        logic [31:0] h;
        logic [6:0]  op;
        h = lcg(lcg({2'b00, addr[31:2]} ^ 32'h5bd9));
        case (h[29:28])
            2'd0: op = fetch_pkg::OP_BRANCH;
            2'd1: op = fetch_pkg::OP_JAL;
            2'd2: op = fetch_pkg::OP_JALR;
            default: op = 7'b0010011;
        endcase
        return {h[31:20], pick_reg(h[17:16]), h[14:12], pick_reg(h[9:8]), op};
    endfunction

    fetch_stage fetch_stage_inst (.*);

    fetch_checker fetch_checker_inst (.*);

    bind fetch_stage fetch_stage_sva fetch_stage_sva_inst (.*);

    // ----------------------------------------
    // Cache, queue and back-end models
    // ----------------------------------------
    task automatic drive_cycle();
        rng = lcg(rng);
        icache_resp_valid = 1'b0;
        if (accept) begin
            pending   = 1'b1;
            pend_cnt  = 1 + int'(rng[31:30]);
            pend_addr = req_addr_q;
        end
        if (pending) begin
            pend_cnt--;
            if (pend_cnt == 0) begin
                icache_resp_valid = 1'b1;
                icache_resp_data  = mem_word(pend_addr);
                pending           = 1'b0;
            end
        end
        icache_req_ready = (rng[29:28] != 2'd0);

        rng = lcg(rng);
        if (stall_cnt > 0) begin
            inst_ready = 1'b0;
            stall_cnt--;
        end else if (rng[31:26] == 6'd0) begin
            // Long queue stall
            inst_ready = 1'b0;
            stall_cnt  = 8 + int'(rng[25:22]);
        end else begin
            inst_ready = (rng[21:20] != 2'd0);
        end

        rng = lcg(rng);
        redirect_valid = (rng[31:26] == 6'd0);
        if (redirect_valid) begin
            redirect_pc       = `FETCH_RESET_PC | {20'd0, rng[21:12], 2'b00};
            pending           = 1'b0;
            icache_resp_valid = 1'b0;
        end

        rng = lcg(rng);
        btb_update_valid  = (rng[31:29] == 3'd0);
        btb_update_pc     = {icache_req_addr[31:4], rng[25:24], 2'b00};
        btb_update_target = `FETCH_RESET_PC | {20'd0, rng[21:12], 2'b00};
    endtask

    always @(posedge clk) begin
        accept     = icache_req_valid && icache_req_ready;
        req_addr_q = icache_req_addr;
        active     = !rst;
        #2;
        if (active) begin
            drive_cycle();
        end
    end

    task automatic wait_items(input int target, input int limit, output logic reached);
        int cycles;
        cycles = 0;
        while (item_count < target && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        reached = (item_count >= target);
        if (!reached) begin
            $display("Timeout: only %0d of %0d instructions reached the queue",
                     item_count, target);
        end
    endtask

    initial begin
        clk               = 1'b0;
        rst               = 1'b1;
        rng               = 32'h5bd9;
        done              = 1'b0;
        redirect_valid    = 1'b0;
        redirect_pc       = '0;
        icache_req_ready  = 1'b0;
        icache_resp_valid = 1'b0;
        icache_resp_data  = '0;
        inst_ready        = 1'b0;
        btb_update_valid  = 1'b0;
        btb_update_pc     = '0;
        btb_update_target = '0;
        pending           = 1'b0;
        pend_cnt          = 0;
        stall_cnt         = 0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        wait_items(600, 60000, ok);
        done = 1'b1;
        #1;
        if (ok && error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: fetch_stage.f
+incdir+src
src/fetch_pkg.sv
src/ras_if.sv
src/fetch_fsm.sv
src/branch_target_buffer.sv
src/return_stack.sv
src/branch_predecode.sv
src/fetch_stage.sv
bench/fetch_stage_sva.sv
bench/fetch_checker.sv
bench/tb_fetch_stage.sv

// File: Makefile
SIM    = verilator
FLAGS  = --binary --timing --assert
TOP    = tb_fetch_stage
FLIST  = fetch_stage.f
LOG    = sim.log

BIN    = obj_dir/V$(TOP)
SRCS   = $(shell grep -v '^+' $(FLIST)) src/fetch_settings.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) -f $(FLIST) --top-module $(TOP) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then exit 1; fi
	@grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
